// File: verilog/koa_cfg.svh
`ifndef KOA_CFG_SVH
`define KOA_CFG_SVH

// ==============================
// Karatsuba multiplier sizing
// ==============================

// Operand width in bits
// Only even widths are supported
`define KOA_SW 24

// Half word, one Karatsuba split
`define KOA_HW (`KOA_SW / 2)

// Left, right and middle products
`define KOA_PHASES 3

`endif

// File: verilog/koa_pkg.sv
package koa_pkg;

    // ==============================
    // Control states
    // ==============================

    // Idle, issue products, then combine
    typedef enum logic [1:0] {
        ST_IDLE    = 2'd0,
        ST_PRODUCT = 2'd1,
        ST_COMBINE = 2'd2
    } koa_state_e;

    // ==============================
    // Opcodes and phases
    // ==============================

    // Square reuses operand A for both inputs
    typedef enum logic [0:0] {
        OP_MUL    = 1'b0,
        OP_SQUARE = 1'b1
    } koa_op_e;

    // Order of issue through the shared multiplier
    typedef enum logic [1:0] {
        PH_LEFT   = 2'd0,
        PH_RIGHT  = 2'd1,
        PH_MIDDLE = 2'd2
    } koa_phase_e;

endpackage

// File: verilog/koa_pp_if.sv
`timescale 1ns/1ps

// One partial product per cycle from the shared multiplier
interface koa_pp_if #(
    parameter int unsigned DATA_W = 26
);

    // Strobe for a fresh product
    logic                    pp_valid;
    // Which of the three products
    koa_pkg::koa_phase_e     pp_phase;
    // Third and final product of the operation
    logic                    pp_last;
    // Product of two half-word operands plus carry bits
    logic [DATA_W-1:0]       pp_data;

    // Operand unit side
    modport src (
        output pp_valid,
        output pp_phase,
        output pp_last,
        output pp_data
    );

    // Combiner side, no back-pressure
    modport dst (
        input pp_valid,
        input pp_phase,
        input pp_last,
        input pp_data
    );

endinterface

// File: verilog/koa_ctrl_fsm.sv
`timescale 1ns/1ps

`include "koa_cfg.svh"

module koa_ctrl_fsm (
    input  logic clk,
    input  logic arst_n_i,
    input  logic start_i,
    input  logic last_i,
    output logic capture_o,
    output logic step_en_o,
    output logic finish_o,
    output logic busy_o,
    output logic done_o
);

    // ==============================
    // State register
    // ==============================

    koa_pkg::koa_state_e state_q;
    koa_pkg::koa_state_e state_d;
    logic                done_q;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= koa_pkg::ST_IDLE;
            done_q  <= 1'b0;
        end else begin
            state_q <= state_d;
            // Done trails the combine cycle by one edge
            done_q  <= finish_o;
        end
    end

    // ==============================
    // Next state and capture
    // ==============================

    always_comb begin
        state_d   = state_q;
        capture_o = 1'b0;
        case (state_q)
            koa_pkg::ST_IDLE: begin
                // Start only honoured here, so busy starts drop out
                if (start_i) begin
                    capture_o = 1'b1;
                    state_d   = koa_pkg::ST_PRODUCT;
                end
            end
            koa_pkg::ST_PRODUCT: begin
                // Counter flags the middle phase as the last one
                if (last_i) begin
                    state_d = koa_pkg::ST_COMBINE;
                end
            end
            koa_pkg::ST_COMBINE: begin
                state_d = koa_pkg::ST_IDLE;
            end
            default: begin
                state_d = koa_pkg::ST_IDLE;
            end
        endcase
    end

    // Products issued on every cycle of ST_PRODUCT
    assign step_en_o = (state_q == koa_pkg::ST_PRODUCT);

    // Middle product sits on the interface during combine
    assign finish_o  = (state_q == koa_pkg::ST_COMBINE);

    // Low again in the done cycle, so back to back starts work
    assign busy_o    = (state_q != koa_pkg::ST_IDLE);
    assign done_o    = done_q;

endmodule

// File: verilog/koa_phase_counter.sv
`timescale 1ns/1ps

`include "koa_cfg.svh"

module koa_phase_counter (
    input  logic                clk,
    input  logic                arst_n_i,
    input  logic                clear_i,
    input  logic                step_i,
    output koa_pkg::koa_phase_e phase_o,
    output logic                last_o
);

    // Final phase derived from the product count
    localparam koa_pkg::koa_phase_e PH_FINAL = koa_pkg::koa_phase_e'(`KOA_PHASES - 1);

    koa_pkg::koa_phase_e phase_q;

    // ==============================
    // Phase sequence
    // ==============================

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            phase_q <= koa_pkg::PH_LEFT;
        end else if (clear_i) begin
            // New operation always begins with the upper halves
            phase_q <= koa_pkg::PH_LEFT;
        end else if (step_i && (phase_q != PH_FINAL)) begin
            case (phase_q)
                koa_pkg::PH_LEFT:  phase_q <= koa_pkg::PH_RIGHT;
                koa_pkg::PH_RIGHT: phase_q <= koa_pkg::PH_MIDDLE;
                default:           phase_q <= PH_FINAL;
            endcase
        end
    end

    // Saturates here until the next clear
    assign last_o  = (phase_q == PH_FINAL);
    assign phase_o = phase_q;

endmodule

// File: verilog/koa_operand_unit.sv
`timescale 1ns/1ps

`include "koa_cfg.svh"

module koa_operand_unit (
    input  logic                clk,
    input  logic                arst_n_i,
    input  logic                capture_i,
    input  logic                step_i,
    input  koa_pkg::koa_phase_e phase_i,
    input  logic                last_i,
    input  logic                op_i,
    input  logic [`KOA_SW-1:0]  data_a_i,
    input  logic [`KOA_SW-1:0]  data_b_i,
    koa_pp_if.src               pp
);

    // ==============================
    // Operand capture
    // ==============================

    koa_pkg::koa_op_e     op_sel;
    logic [`KOA_SW-1:0]   b_sel;
    logic [`KOA_SW-1:0]   a_q;
    logic [`KOA_SW-1:0]   b_q;
    logic [`KOA_HW:0]     sum_a_q;
    logic [`KOA_HW:0]     sum_b_q;

    assign op_sel = koa_pkg::koa_op_e'(op_i);

    // Square feeds A to both sides, B is don't care
    assign b_sel = (op_sel == koa_pkg::OP_SQUARE) ? data_a_i : data_b_i;

    // Operand payload, held for the whole operation
    always_ff @(posedge clk) begin
        if (capture_i) begin
            a_q     <= data_a_i;
            b_q     <= b_sel;
            // Extra bit keeps the carry of each half sum
            sum_a_q <= {1'b0, data_a_i[`KOA_SW-1:`KOA_HW]} + {1'b0, data_a_i[`KOA_HW-1:0]};
            sum_b_q <= {1'b0, b_sel[`KOA_SW-1:`KOA_HW]} + {1'b0, b_sel[`KOA_HW-1:0]};
        end
    end

    // ==============================
    // Shared half-word multiplier
    // ==============================

    logic [`KOA_HW:0]     mul_x;
    logic [`KOA_HW:0]     mul_y;
    logic [2*`KOA_HW+1:0] mul_p;

    // Operand pair per phase
    always_comb begin
        case (phase_i)
            koa_pkg::PH_LEFT: begin
                mul_x = {1'b0, a_q[`KOA_SW-1:`KOA_HW]};
                mul_y = {1'b0, b_q[`KOA_SW-1:`KOA_HW]};
            end
            koa_pkg::PH_RIGHT: begin
                mul_x = {1'b0, a_q[`KOA_HW-1:0]};
                mul_y = {1'b0, b_q[`KOA_HW-1:0]};
            end
            default: begin
                mul_x = sum_a_q;
                mul_y = sum_b_q;
            end
        endcase
    end

    // Both factors widened to the product width
    assign mul_p = {{(`KOA_HW+1){1'b0}}, mul_x} * {{(`KOA_HW+1){1'b0}}, mul_y};

    // Strobes cleared on reset
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pp.pp_valid <= 1'b0;
            pp.pp_last  <= 1'b0;
        end else begin
            pp.pp_valid <= step_i;
            pp.pp_last  <= step_i & last_i;
        end
    end

    // Product and its tag
    always_ff @(posedge clk) begin
        if (step_i) begin
            pp.pp_phase <= phase_i;
            pp.pp_data  <= mul_p;
        end
    end

endmodule

// File: verilog/koa_combine.sv
`timescale 1ns/1ps

`include "koa_cfg.svh"

module koa_combine (
    input  logic                  clk,
    input  logic                  arst_n_i,
    koa_pp_if.dst                 pp,
    input  logic                  finish_i,
    output logic [2*`KOA_SW-1:0]  result_o
);

    // ==============================
    // Partial product store
    // ==============================

    logic [2*`KOA_HW-1:0] left_q;
    logic [2*`KOA_HW-1:0] right_q;
    logic [2*`KOA_HW+1:0] mid_q;

    // Left and right products never use the top two bits
    always_ff @(posedge clk) begin
        if (pp.pp_valid) begin
            case (pp.pp_phase)
                koa_pkg::PH_LEFT:  left_q  <= pp.pp_data[2*`KOA_HW-1:0];
                koa_pkg::PH_RIGHT: right_q <= pp.pp_data[2*`KOA_HW-1:0];
                default:           mid_q   <= pp.pp_data;
            endcase
        end
    end

    // ==============================
    // Middle term and final add
    // ==============================

    logic [2*`KOA_HW+1:0] mid_prod;
    logic [2*`KOA_HW+1:0] mid_term;
    logic [2*`KOA_SW-1:0] left_sh;
    logic [2*`KOA_SW-1:0] mid_sh;
    logic [2*`KOA_SW-1:0] right_ext;
    logic [2*`KOA_SW-1:0] result_d;
    logic [2*`KOA_SW-1:0] result_q;

    // Middle product is still on the interface in the finish cycle
    assign mid_prod = pp.pp_last ? pp.pp_data : mid_q;

    // Cross terms aH*bL + aL*bH
    // Never negative, fits in the product width
    assign mid_term = mid_prod - {2'b00, left_q} - {2'b00, right_q};

    // Place each term at its weight
    assign left_sh   = {left_q, {`KOA_SW{1'b0}}};
    assign mid_sh    = {{(`KOA_SW-`KOA_HW-2){1'b0}}, mid_term, {`KOA_HW{1'b0}}};
    assign right_ext = {{`KOA_SW{1'b0}}, right_q};

    assign result_d = left_sh + mid_sh + right_ext;

    // Result holds between finishes
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            result_q <= '0;
        end else if (finish_i) begin
            result_q <= result_d;
        end
    end

    assign result_o = result_q;

endmodule

// File: verilog/koa_top.sv
`timescale 1ns/1ps

`include "koa_cfg.svh"

module koa_top (
    input  logic                 clk,
    input  logic                 arst_n_i,
    input  logic                 start_i,
    input  logic                 op_i,
    input  logic [`KOA_SW-1:0]   data_a_i,
    input  logic [`KOA_SW-1:0]   data_b_i,
    output logic                 busy_o,
    output logic                 done_o,
    output logic [2*`KOA_SW-1:0] result_o
);

    // Split needs two equal halves
    if ((`KOA_SW % 2) != 0) begin : g_width_check
        $error("KOA_SW must be even");
    end

    // ==============================
    // Control wiring
    // ==============================

    logic                capture;
    logic                step_en;
    logic                finish;
    logic                last;
    koa_pkg::koa_phase_e phase;

    // Half-word product plus two carry bits
    koa_pp_if #(.DATA_W(2*`KOA_HW+2)) pp_bus ();

    koa_ctrl_fsm u_ctrl_fsm (
        .clk       (clk),
        .arst_n_i  (arst_n_i),
        .start_i   (start_i),
        .last_i    (last),
        .capture_o (capture),
        .step_en_o (step_en),
        .finish_o  (finish),
        .busy_o    (busy_o),
        .done_o    (done_o)
    );

    // Cleared by the same capture that loads operands
    koa_phase_counter u_phase_counter (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .clear_i  (capture),
        .step_i   (step_en),
        .phase_o  (phase),
        .last_o   (last)
    );

    // ==============================
    // Datapath
    // ==============================

    koa_operand_unit u_operand_unit (
        .clk       (clk),
        .arst_n_i  (arst_n_i),
        .capture_i (capture),
        .step_i    (step_en),
        .phase_i   (phase),
        .last_i    (last),
        .op_i      (op_i),
        .data_a_i  (data_a_i),
        .data_b_i  (data_b_i),
        .pp        (pp_bus.src)
    );

    koa_combine u_combine (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .pp       (pp_bus.dst),
        .finish_i (finish),
        .result_o (result_o)
    );

endmodule

// File: test/koa_properties.sv
`timescale 1ns/1ps

module koa_properties (
    input logic clk,
    input logic arst_n_i,
    input logic start_i,
    input logic busy_o,
    input logic done_o,
    input logic pp_valid
);

    // Start sampled while idle
    logic accept;
    assign accept = start_i && !busy_o;

    // ==============================
    // Handshake
    // ==============================

    // Single-cycle done strobe
    a_done_pulse: assert property (@(posedge clk) disable iff (!arst_n_i)
        done_o |=> !done_o)
        else $error("done_o held for more than one cycle");

    // Done is raised at edge 4 and sampled one edge later
    a_done_latency: assert property (@(posedge clk) disable iff (!arst_n_i)
        done_o == $past(accept, 5))
        else $error("done_o not 4 edges after an accepted start");

    a_busy_done_excl: assert property (@(posedge clk) disable iff (!arst_n_i)
        !(busy_o && done_o))
        else $error("busy_o and done_o high together");

    // Three products per operation, in consecutive cycles
    a_pp_burst: assert property (@(posedge clk) disable iff (!arst_n_i)
        pp_valid == ($past(accept, 2) || $past(accept, 3) || $past(accept, 4)))
        else $error("pp_valid not a burst of three after an accepted start");

endmodule

bind koa_top koa_properties u_koa_properties (
    .clk      (clk),
    .arst_n_i (arst_n_i),
    .start_i  (start_i),
    .busy_o   (busy_o),
    .done_o   (done_o),
    .pp_valid (pp_bus.pp_valid)
);

// File: test/koa_tb.sv
`timescale 1ns/1ps

`include "koa_cfg.svh"

module koa_tb;

    localparam int SW             = `KOA_SW;
    localparam int HW             = `KOA_HW;
    localparam int N_OPS          = 300;
    localparam int RESET_CYCLES   = 16;
    localparam int TIMEOUT_CYCLES = N_OPS * 8 + RESET_CYCLES;

    logic            clk;
    logic            arst_n_i;
    logic            start_i;
    logic            op_i;
    logic [SW-1:0]   data_a_i;
    logic [SW-1:0]   data_b_i;
    logic            busy_o;
    logic            done_o;
    logic [2*SW-1:0] result_o;

    // Model state, edges counted from reset release
    int              cyc;
    int              accept_edge;
    int              gap;
    int              n_accepted;
    int              n_done;
    int              n_ignored;
    int              n_back_to_back;
    int              n_square;
    int              error_count;
    int              cycle_count;
    logic [2*SW-1:0] pend_result;
    logic [2*SW-1:0] held_result;

    koa_top u_koa_top (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .start_i  (start_i),
        .op_i     (op_i),
        .data_a_i (data_a_i),
        .data_b_i (data_b_i),
        .busy_o   (busy_o),
        .done_o   (done_o),
        .result_o (result_o)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ==============================
    // Helpers
    // ==============================

    task automatic abort_run();
        error_count++;
        $display("STATUS: FAIL");
        $fatal(1, "Stopping at the first error");
    endtask

    // Zero and all-ones halves hit the carry of the half sums
    function automatic logic [HW-1:0] pick_half();
        logic [31:0] rnd;
        logic [31:0] sel;
        rnd = $urandom;
        sel = $urandom % 4;
        case (sel)
            0:       pick_half = '0;
            1:       pick_half = '1;
            default: pick_half = rnd[HW-1:0];
        endcase
    endfunction

    // Inputs for the next rising edge
    task automatic drive_cycle();
        logic [31:0]     rnd;
        logic [2*SW-1:0] a_ext;
        logic [2*SW-1:0] b_ext;
        rnd      = $urandom;
        data_a_i = {pick_half(), pick_half()};
        // Garbage on B also for squares
        data_b_i = {pick_half(), pick_half()};
        op_i     = rnd[0];
        start_i  = 1'b0;
        if (n_accepted < N_OPS && gap == 0) begin
            start_i = 1'b1;
            gap     = $urandom % 4;
            // Idle again only from the done cycle on
            if (cyc + 1 >= accept_edge + 5) begin
                if (cyc + 1 == accept_edge + 5) begin
                    n_back_to_back++;
                end
                accept_edge = cyc + 1;
                n_accepted++;
                a_ext = {{SW{1'b0}}, data_a_i};
                b_ext = {{SW{1'b0}}, data_b_i};
                if (op_i == koa_pkg::OP_SQUARE) begin
                    b_ext = a_ext;
                    n_square++;
                end
                pend_result = a_ext * b_ext;
            end else begin
                n_ignored++;
            end
        end else if (gap > 0) begin
            gap--;
        end
    endtask

    // Outputs after edge cyc, sampled on the falling edge
    task automatic check_cycle();
        logic exp_busy;
        logic exp_done;
        exp_busy = (cyc >= accept_edge) && (cyc <= accept_edge + 3);
        exp_done = (cyc == accept_edge + 4);
        if (exp_done) begin
            held_result = pend_result;
            n_done++;
        end
        assert (busy_o == exp_busy) else begin
            $display("Mismatch at %0t: busy_o = %b, expected %b", $time, busy_o, exp_busy);
            abort_run();
        end
        assert (done_o == exp_done) else begin
            $display("Mismatch at %0t: done_o = %b, expected %b", $time, done_o, exp_done);
            abort_run();
        end
        // Held between strobes while inputs move
        assert (result_o == held_result) else begin
            $display("Mismatch at %0t: result_o = %h, expected %h",
                     $time, result_o, held_result);
            abort_run();
        end
    endtask

    // ==============================
    // Stimulus and checks
    // ==============================

    initial begin
        void'($urandom(10));
        arst_n_i       = 1'b0;
        start_i        = 1'b0;
        op_i           = 1'b0;
        data_a_i       = '0;
        data_b_i       = '0;
        cyc            = 0;
        accept_edge    = -100;
        gap            = 0;
        n_accepted     = 0;
        n_done         = 0;
        n_ignored      = 0;
        n_back_to_back = 0;
        n_square       = 0;
        error_count    = 0;
        pend_result    = '0;
        held_result    = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        arst_n_i = 1'b1;
        assert (!busy_o && !done_o && result_o == '0) else begin
            $display("Mismatch at %0t: outputs not idle and zero after reset", $time);
            abort_run();
        end
        while (n_done < N_OPS) begin
            drive_cycle();
            @(negedge clk);
            cyc++;
            check_cycle();
        end
        // No stray done after the last operation
        start_i = 1'b0;
        repeat (3) begin
            @(negedge clk);
            cyc++;
            check_cycle();
        end
        assert (n_ignored > 0 && n_back_to_back > 0 && n_square > 0 && n_square < N_OPS)
        else begin
            $display("Stimulus missed busy starts, back to back starts or an opcode");
            abort_run();
        end
        if (error_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    // Run limit from the worst spacing of operations
    initial begin
        cycle_count = 0;
        forever begin
            @(posedge clk);
            cycle_count++;
            if (cycle_count > TIMEOUT_CYCLES) begin
                $display("Timeout after %0d cycles with %0d of %0d results seen",
                         TIMEOUT_CYCLES, n_done, N_OPS);
                $display("STATUS: FAIL");
                $fatal(1, "Run did not complete in time");
            end
        end
    end

endmodule

// File: project.f
+incdir+verilog
verilog/koa_pkg.sv
verilog/koa_pp_if.sv
verilog/koa_ctrl_fsm.sv
verilog/koa_phase_counter.sv
verilog/koa_operand_unit.sv
verilog/koa_combine.sv
verilog/koa_top.sv
test/koa_properties.sv
test/koa_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the Karatsuba multiplier testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f --top-module koa_tb -o koa_sim \
    > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/koa_sim > sim.log 2>&1
cat sim.log

# The log decides the outcome, not the exit code of the simulator
grep -q "^STATUS: PASS$" sim.log && echo "Simulation passed" && exit 0 || echo "Simulation failed"
exit 1
